/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_membus_csr_adapter \
  -f sources.f --Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error status."
cat sim.log 2>/dev/null
if [ ! -f sim.log ] || grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST OK" sim.log || exit 1
exit 0

/* source/csr_adapter_pkg.sv */
/*
  Shared widths, opcodes and channel structs of the memory-bus to CSR-bus adapter.
  Imported by every adapter module and by the testbench.
*/
`default_nettype none

package csr_adapter_pkg;

  // Memory-bus beat and CSR unit geometry.
  localparam int MEM_DATA_WIDTH   = 128;
  localparam int UNIT_WIDTH       = 32;
  localparam int UNIT_BYTES       = 4;
  localparam int UNITS_PER_BEAT   = 4;
  localparam int UNIT_INDEX_WIDTH = 2;
  localparam int UNIT_ADDR_LSB    = 2;  // Byte offset bits inside a unit.

  localparam int ADDR_WIDTH       = 16;
  localparam int ID_WIDTH         = 4;
  localparam int BURST_WIDTH      = 3;  // 1 to 7 beats.
  localparam int UNIT_COUNT_WIDTH = 5;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_cmd_e;

  typedef enum logic {
    CSR_READ,
    CSR_WRITE
  } csr_cmd_e;

  typedef enum logic [1:0] {
    IDLE,
    READ_ISSUE,
    WRITE_ISSUE
  } fsm_state_e;

  typedef struct packed {
    mem_cmd_e                   cmd;
    logic [ADDR_WIDTH-1:0]      addr;
    logic [BURST_WIDTH-1:0]     beats;
    logic [ID_WIDTH-1:0]        id;
  } mem_cmd_t;

  typedef struct packed {
    logic [MEM_DATA_WIDTH-1:0]   data;
    logic [MEM_DATA_WIDTH/8-1:0] byte_en;
    logic                        last;
  } mem_wdata_t;

  typedef struct packed {
    csr_cmd_e                   cmd;
    logic [ADDR_WIDTH-1:0]      addr;
    logic [UNIT_WIDTH-1:0]      data;
  } csr_cmd_t;

  typedef struct packed {
    logic [UNIT_WIDTH-1:0]      data;
    logic                       error;
  } csr_resp_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]        id;
    logic [MEM_DATA_WIDTH-1:0]  data;
    logic                       last;
    logic                       error;
  } mem_resp_t;

  // One entry per outstanding read.
  typedef struct packed {
    logic [ID_WIDTH-1:0]         id;
    logic [UNIT_COUNT_WIDTH-1:0] units;
    logic [UNIT_INDEX_WIDTH-1:0] start_index;
  } resp_info_t;

endpackage

`default_nettype wire

/* source/csr_request_fsm.sv */
/*
  Request side of the adapter. Takes memory commands and write beats and
  issues one CSR command per 32-bit unit, stepping the unit counter.
*/
`timescale 1ns/1ns
`default_nettype none

module csr_request_fsm #(
  parameter int BURST_MAX = 7
)(
  input  var logic                                          i_clk,
  input  var logic                                          i_rst_n,
  input  var logic                                          i_mem_cmd_valid,
  output logic                                              o_mem_cmd_accept,
  input  var csr_adapter_pkg::mem_cmd_t                     i_mem_cmd,
  input  var logic                                          i_mem_wdata_valid,
  output logic                                              o_mem_wdata_accept,
  input  var csr_adapter_pkg::mem_wdata_t                   i_mem_wdata,
  output logic                                              o_csr_cmd_valid,
  input  var logic                                          i_csr_cmd_accept,
  output csr_adapter_pkg::csr_cmd_t                         o_csr_cmd,
  input  var logic                                          i_fifo_full,
  output logic                                              o_info_push,
  output csr_adapter_pkg::resp_info_t                       o_info,
  output logic                                              o_cnt_load,
  output logic                                              o_cnt_step,
  output logic [csr_adapter_pkg::ADDR_WIDTH-1:0]            o_load_addr,
  output logic [csr_adapter_pkg::UNIT_COUNT_WIDTH-1:0]      o_load_units,
  input  var logic [csr_adapter_pkg::UNIT_INDEX_WIDTH-1:0]  i_unit_index,
  input  var logic                                          i_unit_last,
  input  var logic [csr_adapter_pkg::ADDR_WIDTH-1:0]        i_csr_addr
);
  import csr_adapter_pkg::*;

  fsm_state_e                  state;
  fsm_state_e                  state_next;
  logic                        cmd_ok;
  logic                        cmd_ack;
  logic                        unit_active;
  logic                        beat_close;
  logic                        unit_done;
  logic [UNIT_INDEX_WIDTH-1:0] start_index;

  always_comb begin
    start_index = i_mem_cmd.addr[UNIT_ADDR_LSB+:UNIT_INDEX_WIDTH];
    cmd_ok      = (int'(i_mem_cmd.beats) <= BURST_MAX) &&
                  ((i_mem_cmd.cmd == MEM_WRITE) || !i_fifo_full);
    unit_active = i_mem_wdata.byte_en[UNIT_BYTES*i_unit_index+:UNIT_BYTES] != '0;
    beat_close  = (i_unit_index == UNIT_INDEX_WIDTH'(UNITS_PER_BEAT - 1)) || i_unit_last;
  end

  always_comb begin
    o_mem_cmd_accept   = 1'b0;
    o_mem_wdata_accept = 1'b0;
    o_csr_cmd_valid    = 1'b0;
    unit_done          = 1'b0;
    case (state)
      IDLE: o_mem_cmd_accept = i_mem_cmd_valid && cmd_ok;
      READ_ISSUE: begin
        o_csr_cmd_valid = 1'b1;
        unit_done       = i_csr_cmd_accept;
      end
      WRITE_ISSUE: begin
        if (unit_active) begin
          o_csr_cmd_valid    = i_mem_wdata_valid;
          o_mem_wdata_accept = beat_close && i_csr_cmd_accept;
          unit_done          = i_mem_wdata_valid && i_csr_cmd_accept;
        end else begin
          // Empty unit skipped without a CSR access.
          o_mem_wdata_accept = beat_close;
          unit_done          = i_mem_wdata_valid;
        end
      end
      default: ;
    endcase
    cmd_ack = i_mem_cmd_valid && o_mem_cmd_accept;
  end

  always_comb begin
    state_next = state;
    if (state == IDLE) begin
      if (cmd_ack && (i_mem_cmd.cmd == MEM_READ)) begin
        state_next = READ_ISSUE;
      end else if (cmd_ack) begin
        state_next = WRITE_ISSUE;
      end
    end else if (unit_done && i_unit_last) begin
      state_next = IDLE;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    o_cnt_load   = cmd_ack;
    o_cnt_step   = unit_done;
    o_load_addr  = i_mem_cmd.addr;
    o_load_units = UNIT_COUNT_WIDTH'(i_mem_cmd.beats * UNITS_PER_BEAT) -
                   UNIT_COUNT_WIDTH'(start_index);  // Leading units skipped.

    o_info_push       = cmd_ack && (i_mem_cmd.cmd == MEM_READ);
    o_info.id          = i_mem_cmd.id;
    o_info.units       = o_load_units;
    o_info.start_index = start_index;

    o_csr_cmd.cmd  = (state == WRITE_ISSUE) ? CSR_WRITE : CSR_READ;
    o_csr_cmd.addr = i_csr_addr;
    o_csr_cmd.data = i_mem_wdata.data[UNIT_WIDTH*i_unit_index+:UNIT_WIDTH];
  end

endmodule

`default_nettype wire

/* source/membus_csr_adapter.sv */
/*
  Top level of the memory-bus to CSR-bus adapter.
  Connects the request FSM, unit counter, response-info FIFO and read assembler.
*/
`timescale 1ns/1ns
`default_nettype none

module membus_csr_adapter #(
  parameter int BURST_MAX  = 7,
  parameter int INFO_DEPTH = 2  // Max reads in flight.
)(
  input  var logic                         i_clk,
  input  var logic                         i_rst_n,
  input  var logic                         i_mem_cmd_valid,
  output logic                             o_mem_cmd_accept,
  input  var csr_adapter_pkg::mem_cmd_t    i_mem_cmd,
  input  var logic                         i_mem_wdata_valid,
  output logic                             o_mem_wdata_accept,
  input  var csr_adapter_pkg::mem_wdata_t  i_mem_wdata,
  output logic                             o_csr_cmd_valid,
  input  var logic                         i_csr_cmd_accept,
  output csr_adapter_pkg::csr_cmd_t        o_csr_cmd,
  input  var logic                         i_csr_resp_valid,
  output logic                             o_csr_resp_accept,
  input  var csr_adapter_pkg::csr_resp_t   i_csr_resp,
  output logic                             o_mem_resp_valid,
  input  var logic                         i_mem_resp_accept,
  output csr_adapter_pkg::mem_resp_t       o_mem_resp
);
  import csr_adapter_pkg::*;

  logic                        info_full;
  logic                        info_empty;
  logic                        info_push;
  logic                        info_pop;
  resp_info_t                  info_in;
  resp_info_t                  info_head;
  logic                        cnt_load;
  logic                        cnt_step;
  logic [ADDR_WIDTH-1:0]       load_addr;
  logic [UNIT_COUNT_WIDTH-1:0] load_units;
  logic [UNIT_INDEX_WIDTH-1:0] unit_index;
  logic                        unit_last;
  logic [ADDR_WIDTH-1:0]       csr_addr;

  csr_request_fsm #(
    .BURST_MAX (BURST_MAX)
  ) u_fsm (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_mem_cmd_valid    (i_mem_cmd_valid),
    .o_mem_cmd_accept   (o_mem_cmd_accept),
    .i_mem_cmd          (i_mem_cmd),
    .i_mem_wdata_valid  (i_mem_wdata_valid),
    .o_mem_wdata_accept (o_mem_wdata_accept),
    .i_mem_wdata        (i_mem_wdata),
    .o_csr_cmd_valid    (o_csr_cmd_valid),
    .i_csr_cmd_accept   (i_csr_cmd_accept),
    .o_csr_cmd          (o_csr_cmd),
    .i_fifo_full        (info_full),
    .o_info_push        (info_push),
    .o_info             (info_in),
    .o_cnt_load         (cnt_load),
    .o_cnt_step         (cnt_step),
    .o_load_addr        (load_addr),
    .o_load_units       (load_units),
    .i_unit_index       (unit_index),
    .i_unit_last        (unit_last),
    .i_csr_addr         (csr_addr)
  );

  unit_counter u_counter (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_load       (cnt_load),
    .i_step       (cnt_step),
    .i_load_addr  (load_addr),
    .i_load_units (load_units),
    .o_unit_index (unit_index),
    .o_unit_last  (unit_last),
    .o_csr_addr   (csr_addr)
  );

  response_info_fifo #(
    .DEPTH (INFO_DEPTH)
  ) u_info_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (info_push),
    .i_data  (info_in),
    .i_pop   (info_pop),
    .o_data  (info_head),
    .o_empty (info_empty),
    .o_full  (info_full)
  );

  read_data_assembler u_assembler (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_info            (info_head),
    .i_info_empty      (info_empty),
    .o_info_pop        (info_pop),
    .i_csr_resp_valid  (i_csr_resp_valid),
    .o_csr_resp_accept (o_csr_resp_accept),
    .i_csr_resp        (i_csr_resp),
    .o_mem_resp_valid  (o_mem_resp_valid),
    .i_mem_resp_accept (i_mem_resp_accept),
    .o_mem_resp        (o_mem_resp)
  );

endmodule

`default_nettype wire

/* source/read_data_assembler.sv */
/*
  Gathers CSR read units into 128-bit memory-bus response beats.
  Driven by the response-info FIFO head; stalls the CSR response on back-pressure.
*/
`timescale 1ns/1ns
`default_nettype none

module read_data_assembler (
  input  var logic                         i_clk,
  input  var logic                         i_rst_n,
  input  var csr_adapter_pkg::resp_info_t  i_info,
  input  var logic                         i_info_empty,
  output logic                             o_info_pop,
  input  var logic                         i_csr_resp_valid,
  output logic                             o_csr_resp_accept,
  input  var csr_adapter_pkg::csr_resp_t   i_csr_resp,
  output logic                             o_mem_resp_valid,
  input  var logic                         i_mem_resp_accept,
  output csr_adapter_pkg::mem_resp_t       o_mem_resp
);
  import csr_adapter_pkg::*;

  logic                                       active;
  logic [UNIT_COUNT_WIDTH-1:0]                units_left;
  logic [UNIT_INDEX_WIDTH-1:0]                unit_index;
  logic                                       unit_last;
  logic                                       beat_close;
  logic                                       load;
  logic                                       csr_ack;
  logic                                       mem_ack;
  logic                                       error_acc;
  logic [UNITS_PER_BEAT-1:0][UNIT_WIDTH-1:0]  lanes;

  always_comb begin
    load       = !active && !i_info_empty;
    unit_last  = units_left == UNIT_COUNT_WIDTH'(1);
    beat_close = (unit_index == UNIT_INDEX_WIDTH'(UNITS_PER_BEAT - 1)) || unit_last;

    if (!active) begin
      o_csr_resp_accept = 1'b0;
      o_mem_resp_valid  = 1'b0;
    end else if (beat_close) begin
      o_csr_resp_accept = i_mem_resp_accept;  // Slave holds the unit on a stall.
      o_mem_resp_valid  = i_csr_resp_valid;
    end else begin
      o_csr_resp_accept = 1'b1;
      o_mem_resp_valid  = 1'b0;
    end

    csr_ack    = i_csr_resp_valid && o_csr_resp_accept;
    mem_ack    = o_mem_resp_valid && i_mem_resp_accept;
    o_info_pop = mem_ack && unit_last;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      active <= 1'b0;
    end else if (o_info_pop) begin
      active <= 1'b0;
    end else if (load) begin
      active <= 1'b1;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      units_left <= '0;
      unit_index <= '0;
      error_acc  <= 1'b0;
    end else begin
      if (load) begin
        units_left <= i_info.units;
        unit_index <= i_info.start_index;
      end else if (csr_ack) begin
        units_left <= units_left - UNIT_COUNT_WIDTH'(1);
        unit_index <= unit_index + UNIT_INDEX_WIDTH'(1);
      end
      if (mem_ack) error_acc <= 1'b0;
      else if (csr_ack) error_acc <= error_acc | i_csr_resp.error;
    end
  end

  // Lanes below the top one are latched; the current unit passes straight through.
  for (genvar i = 0; i < UNITS_PER_BEAT; i++) begin : g_lane
    if (i < UNITS_PER_BEAT - 1) begin : g_latched
      logic [UNIT_WIDTH-1:0] held;
      logic                  match;

      assign match    = unit_index == UNIT_INDEX_WIDTH'(i);
      assign lanes[i] = match ? i_csr_resp.data : held;

      always_ff @(posedge i_clk) begin
        if (csr_ack && match) held <= i_csr_resp.data;
      end
    end else begin : g_direct
      assign lanes[i] = i_csr_resp.data;
    end
  end

  always_comb begin
    o_mem_resp.id    = i_info.id;
    o_mem_resp.data  = lanes;
    o_mem_resp.last  = unit_last;
    o_mem_resp.error = error_acc | i_csr_resp.error;
  end

endmodule

`default_nettype wire

/* source/response_info_fifo.sv */
/*
  In-order FIFO of read response info. Pushed when a read is accepted,
  popped after the final response beat of that read.
*/
`timescale 1ns/1ns
`default_nettype none

module response_info_fifo #(
  parameter int DEPTH = 2
)(
  input  var logic                         i_clk,
  input  var logic                         i_rst_n,
  input  var logic                         i_push,
  input  var csr_adapter_pkg::resp_info_t  i_data,
  input  var logic                         i_pop,
  output csr_adapter_pkg::resp_info_t      o_data,
  output logic                             o_empty,
  output logic                             o_full
);
  import csr_adapter_pkg::*;

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  resp_info_t             mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  function automatic logic [PTR_WIDTH-1:0] ptr_inc(logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + PTR_WIDTH'(1);
  endfunction

  always_comb begin
    do_push = i_push && !o_full;
    do_pop  = i_pop && !o_empty;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + COUNT_WIDTH'(do_push) - COUNT_WIDTH'(do_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_comb begin
    o_data  = mem[rd_ptr];  // Head entry.
    o_empty = count == '0;
    o_full  = count == COUNT_WIDTH'(DEPTH);
  end

endmodule

`default_nettype wire

/* source/unit_counter.sv */
/*
  Unit counter for the request side. Loaded per command, stepped per unit;
  gives the remaining-unit state, the unit index and the CSR address.
*/
`timescale 1ns/1ns
`default_nettype none

module unit_counter (
  input  var logic                                          i_clk,
  input  var logic                                          i_rst_n,
  input  var logic                                          i_load,
  input  var logic                                          i_step,
  input  var logic [csr_adapter_pkg::ADDR_WIDTH-1:0]        i_load_addr,
  input  var logic [csr_adapter_pkg::UNIT_COUNT_WIDTH-1:0]  i_load_units,
  output logic [csr_adapter_pkg::UNIT_INDEX_WIDTH-1:0]      o_unit_index,
  output logic                                              o_unit_last,
  output logic [csr_adapter_pkg::ADDR_WIDTH-1:0]            o_csr_addr
);
  import csr_adapter_pkg::*;

  logic [UNIT_COUNT_WIDTH-1:0] units_left;
  logic [ADDR_WIDTH-1:0]       addr;
  logic [ADDR_WIDTH-1:0]       addr_next;

  // Next word starts on a 4-byte boundary.
  always_comb begin
    addr_next = {addr[ADDR_WIDTH-1:UNIT_ADDR_LSB], UNIT_ADDR_LSB'(0)} + ADDR_WIDTH'(UNIT_BYTES);
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      units_left <= '0;
      addr       <= '0;
    end else if (i_load) begin
      units_left <= i_load_units;
      addr       <= i_load_addr;
    end else if (i_step) begin
      units_left <= units_left - UNIT_COUNT_WIDTH'(1);
      addr       <= addr_next;
    end
  end

  always_comb begin
    o_unit_index = addr[UNIT_ADDR_LSB+:UNIT_INDEX_WIDTH];
    o_unit_last  = units_left == UNIT_COUNT_WIDTH'(1);
    o_csr_addr   = addr;
  end

endmodule

`default_nettype wire

/* sources.f */
source/csr_adapter_pkg.sv
source/unit_counter.sv
source/response_info_fifo.sv
source/read_data_assembler.sv
source/csr_request_fsm.sv
source/membus_csr_adapter.sv
tests/membus_csr_adapter_props.sv
tests/tb_membus_csr_adapter.sv

/* tests/membus_csr_adapter_props.sv */
/*
  Handshake properties of the request FSM, bound to every csr_request_fsm.
*/
`timescale 1ns/1ns
`default_nettype none

module membus_csr_adapter_props (
  input var logic                              i_clk,
  input var logic                              i_rst_n,
  input var logic                              i_csr_cmd_valid,
  input var logic                              i_csr_cmd_accept,
  input var csr_adapter_pkg::csr_cmd_t         i_csr_cmd,
  input var logic                              i_mem_cmd_valid,
  input var logic                              i_mem_cmd_accept,
  input var csr_adapter_pkg::mem_cmd_t         i_mem_cmd,
  input var logic                              i_fifo_full,
  input var csr_adapter_pkg::fsm_state_e       i_state
);
  import csr_adapter_pkg::*;

  // A stalled CSR command keeps its valid and payload.
  a_csr_cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_csr_cmd_valid && !i_csr_cmd_accept |=> i_csr_cmd_valid && $stable(i_csr_cmd))
    else $error("CSR command changed while stalled");

  a_accept_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_mem_cmd_accept |-> i_state == IDLE)
    else $error("Memory command accepted outside IDLE");

  a_read_not_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_mem_cmd_valid && i_mem_cmd_accept && (i_mem_cmd.cmd == MEM_READ) |-> !i_fifo_full)
    else $error("Read accepted with a full response-info FIFO");

endmodule

bind csr_request_fsm membus_csr_adapter_props u_props (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_csr_cmd_valid  (o_csr_cmd_valid),
  .i_csr_cmd_accept (i_csr_cmd_accept),
  .i_csr_cmd        (o_csr_cmd),
  .i_mem_cmd_valid  (i_mem_cmd_valid),
  .i_mem_cmd_accept (o_mem_cmd_accept),
  .i_mem_cmd        (i_mem_cmd),
  .i_fifo_full      (i_fifo_full),
  .i_state          (state)
);

`default_nettype wire

/* tests/tb_membus_csr_adapter.sv */
/*
  Testbench for the memory-bus to CSR-bus adapter. Applies a table of memory
  commands, models a CSR slave with random stalls and checks every transfer.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_membus_csr_adapter;
  import csr_adapter_pkg::*;

  localparam int          CLK_PERIOD  = 10;
  localparam int          NUM_ENTRIES = 13;
  localparam int          TIMEOUT_NS  = NUM_ENTRIES * 400;
  localparam int          MAX_READS   = 2;  // Reads in flight.
  localparam int          HOLD_ENTRY  = 6;  // Reads from here meet a full info FIFO.
  localparam int          HOLD_CYCLES = 40;
  localparam logic [31:0] LFSR_SEED   = 32'hb6a5d06d;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  typedef struct packed {
    mem_cmd_e               cmd;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [BURST_WIDTH-1:0] beats;
    logic [ID_WIDTH-1:0]    id;
    logic [31:0]            seed;
    logic [15:0]            be_mask;
  } stim_entry_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]       id;
    logic [MEM_DATA_WIDTH-1:0] data;
    logic [UNITS_PER_BEAT-1:0] lane_mask;  // Lanes actually received.
    logic                      last;
    logic                      error;
  } exp_beat_t;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_mem_cmd_valid;
  logic       o_mem_cmd_accept;
  mem_cmd_t   i_mem_cmd;
  logic       i_mem_wdata_valid;
  logic       o_mem_wdata_accept;
  mem_wdata_t i_mem_wdata;
  logic       o_csr_cmd_valid;
  logic       i_csr_cmd_accept;
  csr_cmd_t   o_csr_cmd;
  logic       i_csr_resp_valid;
  logic       o_csr_resp_accept;
  csr_resp_t  i_csr_resp;
  logic       o_mem_resp_valid;
  logic       i_mem_resp_accept;
  mem_resp_t  o_mem_resp;

  stim_entry_t stim [NUM_ENTRIES];
  logic [31:0] slave_mem [256];
  logic [31:0] ref_mem [256];
  csr_cmd_t    exp_csr_q [$];
  exp_beat_t   exp_beat_q [$];
  csr_resp_t   resp_q [$];
  logic [31:0] lfsr;
  int          reads_accepted = 0;
  int          reads_done = 0;
  int          resp_hold_cycles = 0;

  membus_csr_adapter #(
    .BURST_MAX  (7),
    .INFO_DEPTH (MAX_READS)
  ) u_dut (.*);

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic logic [31:0] fill_word(input int index);
    logic [7:0] idx;
    idx = 8'(index);
    return {8'hc5, idx, ~idx, idx ^ 8'h3c};
  endfunction

  function automatic logic [31:0] beat_word(input logic [31:0] seed, input int beat,
                                            input int lane);
    return seed ^ (32'(beat * UNITS_PER_BEAT + lane) * 32'h1111_0101);
  endfunction

  // Galois LFSR stepped once per bit.
  function automatic logic random_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ LFSR_TAPS;
    return out;
  endfunction

  function automatic logic accept_draw();
    logic b0;
    logic b1;
    b0 = random_bit();
    b1 = random_bit();
    return b0 | b1;  // Stall one cycle in four.
  endfunction

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  // Expected CSR commands and response beats of one table entry.
  task automatic expect_entry(input stim_entry_t e);
    logic [ADDR_WIDTH-1:0] a;
    int                    start;
    int                    units;
    int                    lane;
    csr_cmd_t              c;
    exp_beat_t             b;
    start = int'(e.addr[3:2]);
    units = int'(e.beats) * UNITS_PER_BEAT - start;
    a     = e.addr;
    b     = '0;
    b.id  = e.id;
    for (int u = 0; u < units; u++) begin
      lane   = (start + u) % UNITS_PER_BEAT;
      c.addr = a;
      c.data = beat_word(e.seed, (start + u) / UNITS_PER_BEAT, lane);
      if (e.cmd == MEM_WRITE) begin
        if (e.be_mask[lane*4 +: 4] != 4'h0) begin
          c.cmd = CSR_WRITE;
          exp_csr_q.push_back(c);
          ref_mem[a[9:2]] = c.data;
        end
      end else begin
        c.cmd = CSR_READ;
        exp_csr_q.push_back(c);
        b.data[lane*32 +: 32] = ref_mem[a[9:2]];
        b.lane_mask[lane]     = 1'b1;
        b.error               = b.error | a[8];
        if (lane == UNITS_PER_BEAT - 1 || u == units - 1) begin
          b.last = (u == units - 1);
          exp_beat_q.push_back(b);
          b.lane_mask = '0;
          b.error     = 1'b0;
        end
      end
      a = {a[ADDR_WIDTH-1:2] + 14'd1, 2'b00};
    end
  endtask

  task automatic send_command(input stim_entry_t e);
    i_mem_cmd       = '{cmd: e.cmd, addr: e.addr, beats: e.beats, id: e.id};
    i_mem_cmd_valid = 1'b1;
    @(negedge i_clk);
    while (!o_mem_cmd_accept) @(negedge i_clk);
    if (e.cmd == MEM_READ) begin
      check_value(128'(reads_accepted - reads_done < MAX_READS), 128'(1),
                  "reads in flight when a read is accepted");
      reads_accepted++;
    end
    @(posedge i_clk);
    #1;
    i_mem_cmd_valid = 1'b0;
  endtask

  task automatic send_write_beats(input stim_entry_t e);
    mem_wdata_t w;
    for (int b = 0; b < int'(e.beats); b++) begin
      for (int l = 0; l < UNITS_PER_BEAT; l++) begin
        w.data[l*32 +: 32] = beat_word(e.seed, b, l);
      end
      w.byte_en         = e.be_mask;
      w.last            = (b == int'(e.beats) - 1);
      i_mem_wdata       = w;
      i_mem_wdata_valid = 1'b1;
      @(negedge i_clk);
      while (!o_mem_wdata_accept) @(negedge i_clk);
      @(posedge i_clk);
      #1;
    end
    i_mem_wdata_valid = 1'b0;
  endtask

  task automatic handle_csr_command(input csr_cmd_t c);
    csr_cmd_t  e;
    csr_resp_t r;
    check_value(128'(exp_csr_q.size() != 0), 128'(1), "CSR command without expectation");
    e = exp_csr_q.pop_front();
    check_value(128'(c.cmd), 128'(e.cmd), "CSR opcode");
    check_value(128'(c.addr), 128'(e.addr), "CSR address");
    if (e.cmd == CSR_WRITE) begin
      check_value(128'(c.data), 128'(e.data), "CSR write data");
      slave_mem[c.addr[9:2]] = c.data;
    end else begin
      r.data  = slave_mem[c.addr[9:2]];
      r.error = c.addr[8];  // Error window of the slave.
      resp_q.push_back(r);
    end
  endtask

  task automatic check_beat(input mem_resp_t r);
    exp_beat_t e;
    check_value(128'(exp_beat_q.size() != 0), 128'(1), "response beat without expectation");
    e = exp_beat_q.pop_front();
    check_value(128'(r.id), 128'(e.id), "response id");
    check_value(128'(r.last), 128'(e.last), "response last");
    check_value(128'(r.error), 128'(e.error), "response error");
    for (int l = 0; l < UNITS_PER_BEAT; l++) begin
      if (e.lane_mask[l]) begin
        check_value(128'(r.data[l*32 +: 32]), 128'(e.data[l*32 +: 32]), "response lane data");
      end
    end
    if (e.last) reads_done++;
  endtask

  // CSR slave and response sink; transfers are sampled at the falling edge.
  initial begin : slave_model
    csr_cmd_t  cmd_seen;
    mem_resp_t beat_seen;
    logic      cmd_fire;
    logic      resp_fire;
    logic      beat_fire;
    lfsr              = LFSR_SEED;
    i_csr_cmd_accept  = 1'b0;
    i_csr_resp_valid  = 1'b0;
    i_csr_resp        = '0;
    i_mem_resp_accept = 1'b0;
    for (int i = 0; i < 256; i++) begin
      slave_mem[8'(i)] = fill_word(i);
    end
    forever begin
      @(negedge i_clk);
      cmd_fire  = o_csr_cmd_valid && i_csr_cmd_accept;
      resp_fire = i_csr_resp_valid && o_csr_resp_accept;
      beat_fire = o_mem_resp_valid && i_mem_resp_accept;
      cmd_seen  = o_csr_cmd;
      beat_seen = o_mem_resp;
      @(posedge i_clk);
      #1;
      if (cmd_fire) handle_csr_command(cmd_seen);
      if (resp_fire) void'(resp_q.pop_front());
      if (beat_fire) check_beat(beat_seen);
      i_csr_resp_valid = resp_q.size() != 0;
      if (resp_q.size() != 0) i_csr_resp = resp_q[0];
      i_csr_cmd_accept = accept_draw();
      if (resp_hold_cycles > 0) begin
        i_mem_resp_accept = 1'b0;  // Long stall of the response sink.
        resp_hold_cycles--;
      end else begin
        i_mem_resp_accept = accept_draw();
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired.");
  end

  initial begin
    i_rst_n           = 1'b0;
    i_mem_cmd_valid   = 1'b0;
    i_mem_cmd         = '0;
    i_mem_wdata_valid = 1'b0;
    i_mem_wdata       = '0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[8'(i)] = fill_word(i);
    end
    stim[0]  = '{MEM_WRITE, 16'h0040, 3'd1, 4'h1, 32'h1000_0a00, 16'hffff};
    stim[1]  = '{MEM_WRITE, 16'h0080, 3'd2, 4'h2, 32'h2000_0b00, 16'h0f0f};  // Odd lanes empty.
    stim[2]  = '{MEM_WRITE, 16'h0104, 3'd2, 4'h3, 32'h3000_0c00, 16'hffff};
    stim[3]  = '{MEM_READ,  16'h0044, 3'd1, 4'h3, 32'h0, 16'h0};
    stim[4]  = '{MEM_READ,  16'h0088, 3'd3, 4'h5, 32'h0, 16'h0};
    stim[5]  = '{MEM_READ,  16'h00f8, 3'd2, 4'h6, 32'h0, 16'h0};  // Error in the second beat.
    stim[6]  = '{MEM_READ,  16'h0100, 3'd1, 4'h7, 32'h0, 16'h0};
    stim[7]  = '{MEM_READ,  16'h0000, 3'd2, 4'h8, 32'h0, 16'h0};
    stim[8]  = '{MEM_READ,  16'h0200, 3'd1, 4'h9, 32'h0, 16'h0};
    stim[9]  = '{MEM_WRITE, 16'h0010, 3'd1, 4'h4, 32'h4000_0d00, 16'h0000};
    stim[10] = '{MEM_WRITE, 16'h03f0, 3'd1, 4'hc, 32'h5000_0e00, 16'hf00f};
    stim[11] = '{MEM_READ,  16'h0010, 3'd1, 4'ha, 32'h0, 16'h0};
    stim[12] = '{MEM_READ,  16'h03f0, 3'd1, 4'hb, 32'h0, 16'h0};
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (i == HOLD_ENTRY) resp_hold_cycles = HOLD_CYCLES;
      expect_entry(stim[i]);
      send_command(stim[i]);
      if (stim[i].cmd == MEM_WRITE) send_write_beats(stim[i]);
    end

    while (exp_csr_q.size() != 0 || exp_beat_q.size() != 0) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
    check_value(128'(resp_q.size()), 128'(0), "CSR responses left over");
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
